// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tdc_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
rtl/tdc_pkg.sv
rtl/sample_deser.sv
rtl/thermo_encoder.sv
rtl/tdc_controller.sv
rtl/tdc_top.sv
verification/tdc_tb.sv

// File: rtl/sample_deser.sv
`timescale 1ns/1ps
`default_nettype none

module sample_deser
	import tdc_pkg::*;
(
	input wire CLK_FAST,
	input wire CLK_SLOW,
	input wire rst,
	input wire dly_sample_t sample_in,
	output hit_status_t hit_status,
	output fine_time_t sel_fine,
	output dly_sample_t selected_sample
);

	// fast shift register, index 0 holds the newest snapshot
	dly_sample_t samples [CLK_RATIO];
	// copy of the shift register in the slow domain
	dly_sample_t samples_slow [CLK_RATIO];

	logic [CLK_RATIO-1:0] hit_flags;
	logic [CLK_RATIO-2:0] miss_flags;
	logic [FINE_BITS-1:0] mux_addr;
	fine_time_t cur_fine;
	// fine time of the previous group, kept only for duplicate suppression
	fine_time_t prev_fine;
	logic dup_newest;

	// every fast edge pushes the new snapshot in and ages the others by one slot
	always_ff @(posedge CLK_FAST) begin
		samples[0] <= sample_in;
		for (int i = 1; i < CLK_RATIO; i++) begin
			samples[i] <= samples[i-1];
		end
	end

	// the slow edge is aligned to a fast edge and takes the register before it shifts,
	// so the three copied snapshots are the three fast periods of the slow cycle that ended
	always_ff @(posedge CLK_SLOW) begin
		for (int i = 0; i < CLK_RATIO; i++) begin
			samples_slow[i] <= samples[i];
		end
	end

	// a snapshot holds the edge when its head still shows the leading level
	// and its tail already shows the trailing level
	// two bits are checked at each end so a single bubble there does not hide the edge
	for (genvar k = 0; k < CLK_RATIO; k++) begin : g_hit
		assign hit_flags[k] =
			((samples_slow[k][0] == INTERNALLY_RISING) ||
			(samples_slow[k][1] == INTERNALLY_RISING)) &&
			((samples_slow[k][DLY_BITS-2] == ~INTERNALLY_RISING) ||
			(samples_slow[k][DLY_BITS-1] == ~INTERNALLY_RISING));
	end

	// the edge slipped between two snapshots when the newer one is fully past it
	// and the older one has not seen it yet
	// this happens when the line is shorter than one fast period
	for (genvar k = 0; k < CLK_RATIO - 1; k++) begin : g_miss
		assign miss_flags[k] =
			(samples_slow[k] == {DLY_BITS{INTERNALLY_RISING}}) &&
			(samples_slow[k+1] == {DLY_BITS{~INTERNALLY_RISING}});
	end

	// the oldest snapshot with an edge wins
	always_comb begin
		if (hit_flags[2]) begin
			mux_addr = 2'd2;
		end else if (hit_flags[1]) begin
			mux_addr = 2'd1;
		end else if (hit_flags[0]) begin
			mux_addr = 2'd0;
		end else begin
			// no edge, the middle slot is forwarded and its status stays idle
			mux_addr = 2'd1;
		end
	end

	// the oldest slot is the earliest in time, so the fine time counts down from it
	assign cur_fine = FINE_MAX - mux_addr;

	// an edge right at the end of the newest slot can show up there in two groups in a row
	assign dup_newest = (cur_fine == FINE_MAX) && (prev_fine == FINE_MAX);

	// snapshot and fine time are payload and only mean something together with the status
	always_ff @(posedge CLK_SLOW) begin
		selected_sample <= samples_slow[mux_addr];
		sel_fine <= cur_fine;
	end

	always_ff @(posedge CLK_SLOW) begin
		if (rst) begin
			hit_status <= HIT_IDLE;
			prev_fine <= '0;
		end else begin
			prev_fine <= cur_fine;
			// a miss outranks any hit in the same group
			if (|miss_flags) begin
				hit_status <= HIT_MISSED;
			end else if (|hit_flags && !dup_newest) begin
				hit_status <= HIT_VALID;
			end else begin
				hit_status <= HIT_IDLE;
			end
		end
	end

	// the encoder and the controller decode the status with the same enum,
	// an unused code would pass through both stages unnoticed
	a_status_legal: assert property (
		@(posedge CLK_SLOW) disable iff (rst)
		hit_status inside {HIT_IDLE, HIT_VALID, HIT_MISSED}
	);

endmodule

`default_nettype wire

// File: rtl/tdc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_controller
	import tdc_pkg::*;
(
	input wire CLK_SLOW,
	input wire rst,
	input wire enable,
	input wire hit_status_t hit_status,
	input wire fine_time_t fine_in,
	input wire bin_t bin_in,
	output logic stamp_valid,
	output coarse_t coarse_time,
	output fine_time_t fine_time,
	output bin_t bin,
	output logic miss
);

	// free running slow clock count, wraps silently
	coarse_t coarse_cnt;
	logic accept_hit;
	logic accept_miss;

	// enable only gates the strobes, it never stops the counter
	assign accept_hit = enable && (hit_status == HIT_VALID);
	assign accept_miss = enable && (hit_status == HIT_MISSED);

	// after reset the counter sits one below zero
	// the first edge after release then moves it to 0, so the value held
	// after slow edge n is n
	always_ff @(posedge CLK_SLOW) begin
		if (rst) begin
			coarse_cnt <= '1;
		end else begin
			coarse_cnt <= coarse_cnt + coarse_t'(1);
		end
	end

	// strobes last one cycle because the status is rebuilt every cycle
	always_ff @(posedge CLK_SLOW) begin
		if (rst) begin
			stamp_valid <= 1'b0;
			miss <= 1'b0;
		end else begin
			stamp_valid <= accept_hit;
			miss <= accept_miss;
		end
	end

	// the stamp is held until the next accepted hit
	// at this edge the counter still shows the value of the edge before,
	// which is PIPE_LAT - 1 edges after the capture edge
	always_ff @(posedge CLK_SLOW) begin
		if (accept_hit) begin
			coarse_time <= coarse_cnt - STAMP_BACK;
			fine_time <= fine_in;
			bin <= bin_in;
		end
	end

	// the deserializer gives a miss priority over a hit in the same group,
	// so both strobes at once would mean the stages have lost alignment
	a_strobe_excl: assert property (
		@(posedge CLK_SLOW) disable iff (rst)
		!(stamp_valid && miss)
	);

endmodule

`default_nettype wire

// File: rtl/tdc_pkg.sv
`default_nettype none

package tdc_pkg;

	// number of taps in the external delay line
	localparam int DLY_BITS = 96;

	// fast clock periods per slow clock period
	// the snapshot select logic is written for exactly three slots
	localparam int CLK_RATIO = 3;

	localparam int FINE_BITS = 2;
	// bin has to hold every count from 0 up to DLY_BITS
	localparam int BIN_BITS = 7;
	localparam int COARSE_BITS = 16;

	// the line holds ones before the edge position and zeros after it
	localparam bit INTERNALLY_RISING = 1'b1;

	// slow cycles from the capture edge to the strobe of the controller
	localparam int PIPE_LAT = 3;

	typedef logic [DLY_BITS-1:0] dly_sample_t;
	typedef logic [FINE_BITS-1:0] fine_time_t;
	typedef logic [BIN_BITS-1:0] bin_t;
	typedef logic [COARSE_BITS-1:0] coarse_t;

	// fine index of the newest fast slot, which is the latest in time
	localparam fine_time_t FINE_MAX = fine_time_t'(CLK_RATIO - 1);

	// the counter has advanced this far past the capture edge when a stamp is taken
	localparam coarse_t STAMP_BACK = coarse_t'(PIPE_LAT - 1);

	// status of one snapshot group, shared by every stage
	typedef enum logic [1:0] {
		HIT_IDLE   = 2'd0,
		HIT_VALID  = 2'd1,
		HIT_MISSED = 2'd2
	} hit_status_t;

endpackage

`default_nettype wire

// File: rtl/tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_top
	import tdc_pkg::*;
(
	input wire CLK_FAST,
	input wire CLK_SLOW,
	input wire rst,
	input wire enable,
	input wire dly_sample_t sample_in,
	output logic stamp_valid,
	output coarse_t coarse_time,
	output fine_time_t fine_time,
	output bin_t bin,
	output logic miss
);

	// deserializer to encoder, one slow edge after capture
	hit_status_t deser_status;
	fine_time_t deser_fine;
	dly_sample_t deser_sample;

	// encoder to controller, two slow edges after capture
	hit_status_t enc_status;
	fine_time_t enc_fine;
	bin_t enc_bin;

	sample_deser u_deser (
		.CLK_FAST        (CLK_FAST),
		.CLK_SLOW        (CLK_SLOW),
		.rst             (rst),
		.sample_in       (sample_in),
		.hit_status      (deser_status),
		.sel_fine        (deser_fine),
		.selected_sample (deser_sample)
	);

	thermo_encoder u_enc (
		.CLK_SLOW      (CLK_SLOW),
		.rst           (rst),
		.hit_status_in (deser_status),
		.fine_in       (deser_fine),
		.sample        (deser_sample),
		.hit_status    (enc_status),
		.fine_time     (enc_fine),
		.bin           (enc_bin)
	);

	// the strobes leave here PIPE_LAT slow edges after the capture edge
	tdc_controller u_ctrl (
		.CLK_SLOW    (CLK_SLOW),
		.rst         (rst),
		.enable      (enable),
		.hit_status  (enc_status),
		.fine_in     (enc_fine),
		.bin_in      (enc_bin),
		.stamp_valid (stamp_valid),
		.coarse_time (coarse_time),
		.fine_time   (fine_time),
		.bin         (bin),
		.miss        (miss)
	);

endmodule

`default_nettype wire

// File: rtl/thermo_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module thermo_encoder
	import tdc_pkg::*;
(
	input wire CLK_SLOW,
	input wire rst,
	input wire hit_status_t hit_status_in,
	input wire fine_time_t fine_in,
	input wire dly_sample_t sample,
	output hit_status_t hit_status,
	output fine_time_t fine_time,
	output bin_t bin
);

	bin_t ones_cnt;

	// the edge position is the number of taps that still show the leading level
	// a bubble only moves the count by one, unlike a search for the first transition,
	// which a single flipped tap can throw off by a long way
	always_comb begin
		bin_t cnt;
		cnt = '0;
		for (int i = 0; i < DLY_BITS; i++) begin
			cnt = cnt + bin_t'(sample[i] == INTERNALLY_RISING);
		end
		ones_cnt = cnt;
	end

	// bin and fine time are payload, the status says whether they are valid
	always_ff @(posedge CLK_SLOW) begin
		bin <= ones_cnt;
		fine_time <= fine_in;
	end

	// the status is delayed by the same slow edge as the count so all three stay aligned
	always_ff @(posedge CLK_SLOW) begin
		if (rst) begin
			hit_status <= HIT_IDLE;
		end else begin
			hit_status <= hit_status_in;
		end
	end

	// a count beyond the line length would mean the adder tree is too narrow or broken
	a_bin_range: assert property (
		@(posedge CLK_SLOW) disable iff (rst)
		(hit_status == HIT_VALID) |-> (bin <= bin_t'(DLY_BITS))
	);

endmodule

`default_nettype wire

// File: verification/tdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_tb
	import tdc_pkg::*;
();

	// slow cycles that a single wait may take before the run counts as stuck
	localparam int WAIT_LIMIT = 20;

	logic CLK_FAST;
	logic CLK_SLOW;
	logic rst;
	logic enable;
	dly_sample_t sample_in;
	logic stamp_valid;
	coarse_t coarse_time;
	fine_time_t fine_time;
	bin_t bin;
	logic miss;

	// position of the latest fast edge in the slow period where 0 is the edge shared with CLK_SLOW
	int fast_phase;
	// index of the latest slow edge where the first edge that sees rst low is edge 0
	int slow_edge_cnt;
	integer seed;
	// snapshots for the delay line model in time order with the oldest first
	dly_sample_t line_seq[$];

	tdc_top dut0 (
		.CLK_FAST    (CLK_FAST),
		.CLK_SLOW    (CLK_SLOW),
		.rst         (rst),
		.enable      (enable),
		.sample_in   (sample_in),
		.stamp_valid (stamp_valid),
		.coarse_time (coarse_time),
		.fine_time   (fine_time),
		.bin         (bin),
		.miss        (miss)
	);

	initial begin
		CLK_SLOW = 1'b0;
		forever begin
			#5 CLK_SLOW = ~CLK_SLOW;
		end
	end

	// three fast periods fit in one slow period and the odd picoseconds are spread so that
	// every third rising edge lands exactly on a slow rising edge
	// the phase is updated before the edge so any waiter sees the new value
	initial begin
		CLK_FAST = 1'b0;
		fast_phase = CLK_RATIO - 1;
		#5;
		forever begin
			fast_phase = 0;
			CLK_FAST = 1'b1;
			#1.667;
			CLK_FAST = 1'b0;
			#1.667;
			fast_phase = 1;
			CLK_FAST = 1'b1;
			#1.667;
			CLK_FAST = 1'b0;
			#1.666;
			fast_phase = 2;
			CLK_FAST = 1'b1;
			#1.667;
			CLK_FAST = 1'b0;
			#1.666;
		end
	end

	// the reference count of slow edges gives the expected coarse time of a capture edge
	always @(posedge CLK_SLOW) begin
		if (rst) begin
			slow_edge_cnt <= -1;
		end else begin
			slow_edge_cnt <= slow_edge_cnt + 1;
		end
	end

	// n taps at the head of the line show the leading level and the rest show the trailing one
	function automatic dly_sample_t thermo(input int n_ones);
		dly_sample_t v;
		for (int i = 0; i < DLY_BITS; i++) begin
			v[i] = (i < n_ones) ? INTERNALLY_RISING : ~INTERNALLY_RISING;
		end
		return v;
	endfunction

	// edge positions stay well inside the line so both ends are clean
	function automatic int random_ones();
		return 2 + int'($unsigned($random(seed)) % 93);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_fast_phase(input int phase);
		int n;
		n = 0;
		@(posedge CLK_FAST);
		while (fast_phase != phase) begin
			n++;
			if (n > 2 * CLK_RATIO) begin
				abort_run("the fast clock never reached the requested phase");
			end
			@(posedge CLK_FAST);
		end
	endtask

	// the value driven after the last fast edge of a slow period is taken in at the
	// shared edge and becomes the oldest slot of the next capture, so a group starts there
	// the task returns 1 ns after the last fast edge and before the capture of the last group
	task automatic drive_line();
		wait_fast_phase(CLK_RATIO - 1);
		foreach (line_seq[i]) begin
			#1;
			sample_in = line_seq[i];
			@(posedge CLK_FAST);
		end
		#1;
		sample_in = thermo(0);
	endtask

	// one group with an edge of n ones at the given fine index and idle line elsewhere
	task automatic load_group(input int fine_idx, input dly_sample_t snap);
		for (int f = 0; f < CLK_RATIO; f++) begin
			line_seq.push_back((f == fine_idx) ? snap : thermo(0));
		end
	endtask

	task automatic wait_strobe(output int seen_edge);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		seen_edge = -1;
		while (!done) begin
			@(posedge CLK_SLOW);
			#1;
			n++;
			if (stamp_valid === 1'b1 || miss === 1'b1) begin
				done = 1'b1;
				seen_edge = slow_edge_cnt;
			end else if (n >= WAIT_LIMIT) begin
				abort_run("timeout, neither stamp_valid nor miss rose within 20 slow cycles");
			end
		end
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge CLK_SLOW);
			#1;
			check_value("stamp_valid while quiet", 32'(stamp_valid), 32'd0);
			check_value("miss while quiet", 32'(miss), 32'd0);
		end
	endtask

	// the stamp carries the capture edge count, the slot and the edge position
	task automatic check_stamp(input int cap_edge, input int exp_fine, input int exp_bin);
		int seen;
		wait_strobe(seen);
		check_value("strobe latency", 32'(seen - cap_edge), 32'(PIPE_LAT));
		check_value("stamp_valid", 32'(stamp_valid), 32'd1);
		check_value("miss with stamp", 32'(miss), 32'd0);
		check_value("coarse_time", 32'(coarse_time), 32'(coarse_t'(cap_edge)));
		check_value("fine_time", 32'(fine_time), 32'(exp_fine));
		check_value("bin", 32'(bin), 32'(exp_bin));
		@(posedge CLK_SLOW);
		#1;
		check_value("stamp_valid pulse width", 32'(stamp_valid), 32'd0);
	endtask

	task automatic run_single_edge(input int fine_idx, input int n_ones);
		int cap;
		line_seq.delete();
		load_group(fine_idx, thermo(n_ones));
		drive_line();
		cap = slow_edge_cnt + 1;
		check_stamp(cap, fine_idx, n_ones);
	endtask

	task automatic quiet_after_reset();
		expect_quiet(WAIT_LIMIT);
	endtask

	task automatic stamp_single_edges();
		for (int f = 0; f < CLK_RATIO; f++) begin
			repeat (4) begin
				run_single_edge(f, random_ones());
			end
		end
	endtask

	// the newest slot already past the edge and the one before it still idle
	task automatic detect_miss();
		int cap;
		int seen;
		line_seq.delete();
		load_group(CLK_RATIO - 1, thermo(DLY_BITS));
		drive_line();
		cap = slow_edge_cnt + 1;
		wait_strobe(seen);
		check_value("miss latency", 32'(seen - cap), 32'(PIPE_LAT));
		check_value("miss", 32'(miss), 32'd1);
		check_value("stamp_valid with miss", 32'(stamp_valid), 32'd0);
		@(posedge CLK_SLOW);
		#1;
		check_value("miss pulse width", 32'(miss), 32'd0);
	endtask

	// a hole two taps behind the edge leaves the bin at the number of remaining ones
	task automatic count_with_bubble();
		dly_sample_t v;
		int cap;
		v = thermo(40);
		v[37] = ~INTERNALLY_RISING;
		line_seq.delete();
		load_group(1, v);
		drive_line();
		cap = slow_edge_cnt + 1;
		check_stamp(cap, 1, 39);
	endtask

	// an edge while enable is low must vanish, the next one after it rises is stamped
	task automatic gate_by_enable();
		enable = 1'b0;
		line_seq.delete();
		load_group(0, thermo(60));
		drive_line();
		expect_quiet(WAIT_LIMIT);
		enable = 1'b1;
		run_single_edge(CLK_RATIO - 1, random_ones());
	endtask

	// the same edge in the newest slot of two groups in a row gives one stamp
	// that is taken from the first of the two groups
	task automatic suppress_duplicate();
		int n_ones;
		int cap_first;
		n_ones = random_ones();
		line_seq.delete();
		load_group(CLK_RATIO - 1, thermo(n_ones));
		load_group(CLK_RATIO - 1, thermo(n_ones));
		drive_line();
		cap_first = slow_edge_cnt;
		check_stamp(cap_first, CLK_RATIO - 1, n_ones);
		expect_quiet(WAIT_LIMIT);
	endtask

	initial begin
		seed = 32'h49fd_4cae;
		rst = 1'b1;
		enable = 1'b1;
		sample_in = '0;
		repeat (4) begin
			@(posedge CLK_SLOW);
		end
		#1;
		rst = 1'b0;

		quiet_after_reset();
		stamp_single_edges();
		detect_miss();
		count_with_bubble();
		gate_by_enable();
		suppress_duplicate();

		// every failed check has already stopped the run
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
